/* project.f */
+incdir+rtl
rtl/biquad_pkg.sv
rtl/coef_if.sv
rtl/coef_bank.sv
rtl/fixed_mult.sv
rtl/signed_cast.sv
rtl/biquad.sv
rtl/biquad_chain.sv
verification/biquad_tb.sv

/* rtl/biquad.sv */
`timescale 1ns/10ps

module biquad (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,
    coef_if.section             coefs,
    input  biquad_pkg::sample_t din,
    input  logic                din_valid,
    output biquad_pkg::sample_t dout,
    output logic                dout_valid
);
    import biquad_pkg::*;

    sample_t x1;
    sample_t x2;
    sample_t y1;
    sample_t y2;
    logic    accept;
    prod_t   p_b0;
    prod_t   p_b1;
    prod_t   p_b2;
    prod_t   p_a1;
    prod_t   p_a2;
    logic    prod_valid;
    acc_t    sum;
    logic    sum_valid;

    assign accept = din_valid && !clear;

    // ********************
    // Input history
    // The multipliers capture the old x1 and x2 on the same edge as the shift.
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            x1 <= '0;
            x2 <= '0;
        end else if (accept) begin
            x2 <= x1;
            x1 <= din;
        end
    end

    fixed_mult b0_mult (
        .clk(clk), .rst_n(rst_n), .a(din), .b(coefs.b0), .in_valid(accept),
        .p(p_b0), .out_valid(prod_valid)
    );

    fixed_mult b1_mult (
        .clk(clk), .rst_n(rst_n), .a(x1), .b(coefs.b1), .in_valid(accept),
        .p(p_b1), .out_valid()
    );

    fixed_mult b2_mult (
        .clk(clk), .rst_n(rst_n), .a(x2), .b(coefs.b2), .in_valid(accept),
        .p(p_b2), .out_valid()
    );

    fixed_mult a1_mult (
        .clk(clk), .rst_n(rst_n), .a(y1), .b(coefs.a1), .in_valid(accept),
        .p(p_a1), .out_valid()
    );

    fixed_mult a2_mult (
        .clk(clk), .rst_n(rst_n), .a(y2), .b(coefs.a2), .in_valid(accept),
        .p(p_a2), .out_valid()
    );

    // ********************
    // Accumulate
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            sum <= acc_t'(p_b0) + acc_t'(p_b1) + acc_t'(p_b2)
                 - acc_t'(p_a1) - acc_t'(p_a2);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= prod_valid;
        end
    end

    signed_cast u_cast (
        .clk(clk), .rst_n(rst_n), .din(sum), .in_valid(sum_valid),
        .dout(dout), .out_valid(dout_valid)
    );

    // Output history shifts as the result leaves, one cycle ahead of the next sample.
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            y1 <= '0;
            y2 <= '0;
        end else if (dout_valid) begin
            y2 <= y1;
            y1 <= dout;
        end
    end

endmodule

/* rtl/biquad_chain.sv */
`timescale 1ns/10ps
`include "biquad_defines.svh"

module biquad_chain (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear,
    input  biquad_pkg::sample_t         din,
    input  logic                        din_valid,
    input  logic                        coef_we,
    input  logic [`COEF_ADDR_WIDTH-1:0] coef_addr,
    input  biquad_pkg::coef_t           coef_wdata,
    output biquad_pkg::sample_t         dout,
    output logic                        dout_valid
);
    import biquad_pkg::*;

    // Stage 0 is the chain input and stage SECTIONS is its output.
    sample_t stage_data  [`SECTIONS+1];
    logic    stage_valid [`SECTIONS+1];

    coef_if coefs [`SECTIONS] ();

    // ********************
    // Coefficients
    coef_bank u_coef_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (coef_we),
        .addr  (coef_addr),
        .wdata (coef_wdata),
        .coefs (coefs)
    );

    assign stage_data[0]  = din;
    assign stage_valid[0] = din_valid;

    // ********************
    // Sections
    genvar gs;
    generate
        for (gs = 0; gs < `SECTIONS; gs++) begin : gen_section
            biquad u_section (
                .clk        (clk),
                .rst_n      (rst_n),
                .clear      (clear),
                .coefs      (coefs[gs]),
                .din        (stage_data[gs]),
                .din_valid  (stage_valid[gs]),
                .dout       (stage_data[gs+1]),
                .dout_valid (stage_valid[gs+1])
            );
        end
    endgenerate

    assign dout       = stage_data[`SECTIONS];
    assign dout_valid = stage_valid[`SECTIONS];

endmodule

/* rtl/biquad_defines.svh */
`ifndef BIQUAD_DEFINES_SVH
`define BIQUAD_DEFINES_SVH

// Sample format, Q1.14 in a 16 bit word.
`define DATA_WIDTH 16
`define DATA_POINT 14

// Coefficient format. With 14 fraction bits 1.0 is 16384.
`define COEF_WIDTH 16
`define COEF_POINT 14

// Wide enough for five full products without overflow.
`define ACC_WIDTH 40

`define SECTIONS 2
`define COEF_ADDR_WIDTH 4

// ********************
// Timing
`define MULT_LATENCY 2
`define SECTION_LATENCY 4
`define SAMPLE_GAP_MIN 5

`endif

/* rtl/biquad_pkg.sv */
`include "biquad_defines.svh"

package biquad_pkg;

    // Signed sample word as it travels between sections.
    typedef logic signed [`DATA_WIDTH-1:0] sample_t;

    // Signed filter coefficient.
    typedef logic signed [`COEF_WIDTH-1:0] coef_t;

    // Full precision product of a sample and a coefficient.
    typedef logic signed [`DATA_WIDTH+`COEF_WIDTH-1:0] prod_t;

    // Accumulator that sums the five products of one section.
    typedef logic signed [`ACC_WIDTH-1:0] acc_t;

    // Position of a coefficient inside its section.
    // The write address is section * 5 + index.
    typedef enum logic [2:0] {
        B0 = 3'd0,
        B1 = 3'd1,
        B2 = 3'd2,
        A1 = 3'd3,
        A2 = 3'd4
    } coef_idx_e;

endpackage

/* rtl/coef_bank.sv */
`timescale 1ns/10ps
`include "biquad_defines.svh"

module coef_bank (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we,
    input  logic [`COEF_ADDR_WIDTH-1:0] addr,
    input  biquad_pkg::coef_t           wdata,
    coef_if.bank                        coefs [`SECTIONS]
);
    import biquad_pkg::*;

    localparam int COEFS_PER_SECTION = int'(A2) + 1;

    coef_t bank [`SECTIONS][COEFS_PER_SECTION];

    // ********************
    // Write port
    // An address matches exactly one slot through section * 5 + index, so
    // addresses past the last section never hit a register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `SECTIONS; s++) begin
                for (int k = 0; k < COEFS_PER_SECTION; k++) begin
                    bank[s][k] <= '0;
                end
            end
        end else if (we) begin
            for (int s = 0; s < `SECTIONS; s++) begin
                for (int k = 0; k < COEFS_PER_SECTION; k++) begin
                    if (int'(addr) == s * COEFS_PER_SECTION + k) begin
                        bank[s][k] <= wdata;
                    end
                end
            end
        end
    end

    // ********************
    // Section outputs
    genvar gs;
    generate
        for (gs = 0; gs < `SECTIONS; gs++) begin : gen_drive
            assign coefs[gs].b0 = bank[gs][B0];
            assign coefs[gs].b1 = bank[gs][B1];
            assign coefs[gs].b2 = bank[gs][B2];
            assign coefs[gs].a1 = bank[gs][A1];
            assign coefs[gs].a2 = bank[gs][A2];
        end
    endgenerate

endmodule

/* rtl/coef_if.sv */
`timescale 1ns/10ps

interface coef_if;
    import biquad_pkg::*;

    // Feed forward terms.
    coef_t b0;
    coef_t b1;
    coef_t b2;

    // Feedback terms, subtracted inside the section.
    coef_t a1;
    coef_t a2;

    modport bank (
        output b0, b1, b2, a1, a2
    );

    modport section (
        input b0, b1, b2, a1, a2
    );

endinterface

/* rtl/fixed_mult.sv */
`timescale 1ns/10ps

module fixed_mult (
    input  logic                clk,
    input  logic                rst_n,
    input  biquad_pkg::sample_t a,
    input  biquad_pkg::coef_t   b,
    input  logic                in_valid,
    output biquad_pkg::prod_t   p,
    output logic                out_valid
);
    import biquad_pkg::*;

    sample_t a_reg;
    coef_t   b_reg;
    prod_t   p_reg;
    logic    stage1_valid;

    // Operand registers, then the product register, as in a DSP slice.
    always_ff @(posedge clk) begin
        a_reg <= a;
        b_reg <= b;
        p_reg <= a_reg * b_reg;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage1_valid <= 1'b0;
            out_valid    <= 1'b0;
        end else begin
            stage1_valid <= in_valid;
            out_valid    <= stage1_valid;
        end
    end

    assign p = p_reg;

endmodule

/* rtl/signed_cast.sv */
`timescale 1ns/10ps
`include "biquad_defines.svh"

module signed_cast (
    input  logic                clk,
    input  logic                rst_n,
    input  biquad_pkg::acc_t    din,
    input  logic                in_valid,
    output biquad_pkg::sample_t dout,
    output logic                out_valid
);
    import biquad_pkg::*;

    localparam acc_t SAT_MAX = acc_t'((1 <<< (`DATA_WIDTH - 1)) - 1);
    localparam acc_t SAT_MIN = -acc_t'(1 <<< (`DATA_WIDTH - 1));

    acc_t    shifted;
    sample_t clamped;

    // Arithmetic shift floors toward minus infinity.
    assign shifted = din >>> `COEF_POINT;

    always_comb begin
        if (shifted > SAT_MAX) begin
            clamped = sample_t'(SAT_MAX);
        end else if (shifted < SAT_MIN) begin
            clamped = sample_t'(SAT_MIN);
        end else begin
            clamped = sample_t'(shifted);
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            dout <= clamped;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the biquad chain testbench with Verilator and runs it.
# Exits with a non-zero status when the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing \
    --timescale 1ns/10ps \
    --top-module biquad_tb \
    -Mdir "$BUILD_DIR" \
    -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/Vbiquad_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "Result: FAIL"
    exit 1
fi

echo "Result: PASS"
exit 0

/* verification/biquad_tb.sv */
`timescale 1ns/10ps
`include "biquad_defines.svh"

module biquad_tb;
    import biquad_pkg::*;

    localparam int LATENCY   = `SECTIONS * `SECTION_LATENCY;
    localparam int GAP       = `SAMPLE_GAP_MIN;
    localparam int NUM_COEFS = `SECTIONS * 5;

    logic                        clk;
    logic                        rst_n;
    logic                        clear;
    sample_t                     din;
    logic                        din_valid;
    logic                        coef_we;
    logic [`COEF_ADDR_WIDTH-1:0] coef_addr;
    coef_t                       coef_wdata;
    sample_t                     dout;
    logic                        dout_valid;

    int error_count;
    int check_count;
    int test_errors;
    int tests_run;
    int tests_failed;

    longint stim_q [$];
    longint expect_q [$];
    longint saved_q [$];

    // Software model of the chain, one row of state per section.
    longint model_coef [`SECTIONS][5];
    longint mx1 [`SECTIONS];
    longint mx2 [`SECTIONS];
    longint my1 [`SECTIONS];
    longint my2 [`SECTIONS];

    biquad_chain u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .din        (din),
        .din_valid  (din_valid),
        .coef_we    (coef_we),
        .coef_addr  (coef_addr),
        .coef_wdata (coef_wdata),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

    always #5 clk = ~clk;

    task automatic check(input string name, input logic signed [63:0] expected,
                         input logic signed [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic start_test();
        test_errors = 0;
        tests_run++;
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            $display("[TEST] %s: passed", name);
        end else begin
            $display("[TEST] %s: failed with %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    // ********************
    // Reference model
    function automatic void model_clear();
        for (int s = 0; s < `SECTIONS; s++) begin
            mx1[s] = 0;
            mx2[s] = 0;
            my1[s] = 0;
            my2[s] = 0;
        end
    endfunction

    function automatic longint model_step(input longint x_in);
        longint x;
        longint acc;
        longint y;
        x = x_in;
        for (int s = 0; s < `SECTIONS; s++) begin
            acc = model_coef[s][0] * x + model_coef[s][1] * mx1[s]
                + model_coef[s][2] * mx2[s] - model_coef[s][3] * my1[s]
                - model_coef[s][4] * my2[s];
            // Floor toward minus infinity, then clamp to the sample range.
            y = acc >>> `COEF_POINT;
            if (y > 32767) y = 32767;
            if (y < -32768) y = -32768;
            mx2[s] = mx1[s];
            mx1[s] = x;
            my2[s] = my1[s];
            my1[s] = y;
            x = y;
        end
        return x;
    endfunction

    task automatic predict_all();
        expect_q.delete();
        foreach (stim_q[i]) expect_q.push_back(model_step(stim_q[i]));
    endtask

    function automatic longint random_between(input longint lo, input longint hi);
        return lo + longint'($urandom_range(32'(hi - lo)));
    endfunction

    // ********************
    // Drivers
    task automatic write_coef(input int addr, input longint value);
        @(negedge clk);
        coef_we    = 1'b1;
        coef_addr  = `COEF_ADDR_WIDTH'(addr);
        coef_wdata = coef_t'(value);
        @(negedge clk);
        coef_we = 1'b0;
        if (addr < NUM_COEFS) model_coef[addr / 5][addr % 5] = value;
    endtask

    task automatic load_section(input int s, input longint b0, input longint b1,
                                input longint b2, input longint a1, input longint a2);
        write_coef(s * 5 + int'(B0), b0);
        write_coef(s * 5 + int'(B1), b1);
        write_coef(s * 5 + int'(B2), b2);
        write_coef(s * 5 + int'(A1), a1);
        write_coef(s * 5 + int'(A2), a2);
    endtask

    task automatic load_random_iir();
        for (int s = 0; s < `SECTIONS; s++) begin
            load_section(s, random_between(-8192, 8191), random_between(-8192, 8191),
                         random_between(-8192, 8191), random_between(-8191, 8191),
                         random_between(-4095, 4095));
        end
    endtask

    task automatic pulse_clear();
        @(negedge clk);
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        model_clear();
    endtask

    task automatic load_impulse();
        stim_q.delete();
        stim_q.push_back(16384);
        for (int i = 0; i < 7; i++) stim_q.push_back(0);
    endtask

    // Sends stim_q one sample every GAP cycles while it collects outputs
    // and checks each one against expect_q together with its latency.
    task automatic run_stream(input string name);
        int cycle;
        int sent;
        int got;
        int limit;
        int sent_cycle [$];
        cycle = 0;
        sent  = 0;
        got   = 0;
        limit = stim_q.size() * GAP + LATENCY + 50;
        while (got < expect_q.size() && cycle < limit) begin
            @(negedge clk);
            if (dout_valid === 1'b1) begin
                if (got < sent) begin
                    check(name, expect_q[got], 64'(dout));
                    check(name, 64'(LATENCY), 64'(cycle - sent_cycle[got]));
                end else begin
                    $display("%s: dout_valid rose with no sample in flight", name);
                    error_count++;
                    test_errors++;
                end
                got++;
            end
            if (sent < stim_q.size() && cycle % GAP == 0) begin
                din       = sample_t'(stim_q[sent]);
                din_valid = 1'b1;
                sent_cycle.push_back(cycle);
                sent++;
            end else begin
                din_valid = 1'b0;
            end
            cycle++;
        end
        din_valid = 1'b0;
        if (got < expect_q.size()) begin
            $display("%s: timed out after %0d cycles, got %0d of %0d outputs",
                     name, cycle, got, expect_q.size());
            error_count++;
            test_errors++;
        end
    endtask

    // ********************
    // Tests
    task automatic test_reset_state();
        start_test();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check("reset_state", 64'(0), 64'(dout_valid));
        end
        rst_n = 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check("reset_state", 64'(0), 64'(dout_valid));
        end
        report_test("reset_state");
    endtask

    task automatic test_pass_through();
        start_test();
        for (int s = 0; s < `SECTIONS; s++) load_section(s, 16384, 0, 0, 0, 0);
        pulse_clear();
        stim_q.delete();
        for (int i = 0; i < 6; i++) stim_q.push_back(random_between(-32768, 32767));
        // A unity b0 passes every sample through unchanged.
        expect_q = stim_q;
        run_stream("pass_through");
        report_test("pass_through");
    endtask

    task automatic test_fir_impulse();
        start_test();
        for (int s = 0; s < `SECTIONS; s++) begin
            load_section(s, random_between(-8192, 8191), random_between(-8192, 8191),
                         random_between(-8192, 8191), 0, 0);
        end
        pulse_clear();
        load_impulse();
        predict_all();
        run_stream("fir_impulse");
        report_test("fir_impulse");
    endtask

    task automatic test_iir_recursion();
        start_test();
        load_random_iir();
        pulse_clear();
        stim_q.delete();
        for (int i = 0; i < 40; i++) stim_q.push_back(random_between(-16384, 16383));
        predict_all();
        run_stream("iir_recursion");
        report_test("iir_recursion");
    endtask

    task automatic test_saturation();
        start_test();
        // 2.0 does not fit the coefficient word, so b0 takes the largest value.
        for (int s = 0; s < `SECTIONS; s++) load_section(s, 32767, 0, 0, 0, 0);
        pulse_clear();
        stim_q.delete();
        expect_q.delete();
        for (int i = 0; i < 4; i++) begin
            stim_q.push_back(32767);
            expect_q.push_back(32767);
            stim_q.push_back(-32768);
            expect_q.push_back(-32768);
        end
        run_stream("saturation");
        report_test("saturation");
    endtask

    task automatic test_clear_and_mapping();
        start_test();
        load_random_iir();
        pulse_clear();
        stim_q.delete();
        for (int i = 0; i < 10; i++) stim_q.push_back(random_between(-16384, 16383));
        predict_all();
        run_stream("clear_and_mapping");
        pulse_clear();
        load_impulse();
        predict_all();
        run_stream("clear_and_mapping");
        saved_q = expect_q;
        // Addresses past the last section must not reach any register.
        for (int addr = NUM_COEFS; addr < (1 << `COEF_ADDR_WIDTH); addr++) begin
            write_coef(addr, random_between(-32768, 32767));
        end
        pulse_clear();
        load_impulse();
        expect_q = saved_q;
        run_stream("clear_and_mapping");
        report_test("clear_and_mapping");
    endtask

    initial begin
        void'($urandom(31704));
        clk        = 1'b0;
        rst_n      = 1'b0;
        clear      = 1'b0;
        din        = '0;
        din_valid  = 1'b0;
        coef_we    = 1'b0;
        coef_addr  = '0;
        coef_wdata = '0;
        for (int s = 0; s < `SECTIONS; s++) begin
            for (int k = 0; k < 5; k++) model_coef[s][k] = 0;
        end
        model_clear();

        test_reset_state();
        test_pass_through();
        test_fir_impulse();
        test_iir_recursion();
        test_saturation();
        test_clear_and_mapping();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
